//--- data_memory_subsystem.f
src/nand_cpu_pkg.sv
src/d_cache.sv
src/main_memory.sv
src/data_memory_subsystem.sv
tests/clock_gen.sv
tests/tb_data_memory.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
    --top-module tb_data_memory -f data_memory_subsystem.f -o tb_data_memory \
    && ./obj_dir/tb_data_memory \
    || { echo "build or simulation returned an error" >&2; exit 1; }

//--- tests/tb_data_memory.sv
module tb_data_memory
    import nand_cpu_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int INDEX_BITS = 8;
    localparam int LATENCY = 3;
    localparam int TAG_SHIFT = INDEX_BITS + 2;  // tag sits above index and word offset
    localparam int HIT_TIMEOUT = 64;
    localparam int RANDOM_OPS = 200;

    logic clk;
    logic n_rst;
    logic valid;
    cpu_access_t access;
    cpu_result_t result;

    // expected contents of memory with one entry per CPU word address
    word_t shadow [2**16];
    logic [15:0] lfsr_state;

    clock_gen #(
        .PERIOD(8)
    ) u_clock_gen (
        .clk(clk)
    );

    data_memory_subsystem #(
        .INDEX_BITS(INDEX_BITS),
        .LATENCY   (LATENCY)
    ) UUT (
        .clk   (clk),
        .n_rst (n_rst),
        .valid (valid),
        .access(access),
        .result(result)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("MISMATCH %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic logic [15:0] take_bits(input int count);
        logic [15:0] bits;
        int i;
        bits = '0;
        for (i = 0; i < count; i++) begin
            bits = {bits[14:0], lfsr_state[15]};  // one step for every bit taken
            lfsr_state = lfsr_next(lfsr_state);
        end
        return bits;
    endfunction

    task automatic drive_idle();
        @(posedge clk);
        #1;
        valid = 1'b0;
        access = '0;
    endtask

    // presents one access and holds it until hit, counting the stalled cycles
    task automatic run_access(input mem_op_t op, input addr_t addr, input word_t wdata,
                              output word_t rdata, output int stall_cycles);
        bit done;
        int cycles;
        @(posedge clk);
        #1;
        valid = 1'b1;
        access.mem_access = 1'b1;
        access.mem_op = op;
        access.address = addr;
        access.data = wdata;
        cycles = 0;
        done = 1'b0;
        rdata = '0;
        while (!done) begin
            @(negedge clk);
            if (result.hit) begin
                check_value("result.miss", result.miss, 1'b0);
                rdata = result.data;
                done = 1'b1;
            end else begin
                check_value("result.miss", result.miss, 1'b1);  // a stall is always a miss
                cycles++;
                if (cycles > HIT_TIMEOUT) begin
                    abort_run($sformatf("no hit within %0d cycles for address 0x%04h",
                                        HIT_TIMEOUT, addr));
                end
            end
        end
        stall_cycles = cycles;
        if (op == STORE) begin
            shadow[addr] = wdata;
        end
    endtask

    task automatic load_and_check(input addr_t addr, output int stall_cycles);
        word_t expected;
        word_t rdata;
        expected = shadow[addr];
        run_access(LOAD, addr, 16'h0000, rdata, stall_cycles);
        check_value($sformatf("result.data @0x%04h", addr), rdata, expected);
    endtask

    task automatic test_reset_idle();
        int i;
        @(negedge clk);
        check_value("result.hit", result.hit, 1'b0);
        check_value("result.miss", result.miss, 1'b0);
        @(posedge clk);
        #1;
        valid = 1'b1;
        access.mem_access = 1'b0;  // valid without an access must stay quiet
        access.mem_op = LOAD;
        access.address = 16'h1234;
        for (i = 0; i < 4; i++) begin
            @(negedge clk);
            check_value("result.hit", result.hit, 1'b0);
            check_value("result.miss", result.miss, 1'b0);
        end
        drive_idle();
    endtask

    task automatic test_cold_load();
        int cycles;
        load_and_check(16'h0010, cycles);
        check_value("cold load stalled", cycles != 0, 1'b1);
        load_and_check(16'h0010, cycles);
        check_value("reload stall cycles", cycles, 0);
        drive_idle();
    endtask

    task automatic test_line_stores();
        addr_t base;
        word_t rdata;
        int cycles;
        int w;
        base = 16'h0120;
        for (w = 0; w < BLOCK_WORDS; w++) begin
            run_access(STORE, base + addr_t'(w), 16'hbe00 + word_t'(w * 16'h0011), rdata, cycles);
            if (w == 0) begin
                check_value("first store stalled", cycles != 0, 1'b1);
            end else begin
                check_value("store stall cycles", cycles, 0);
            end
        end
        for (w = 0; w < BLOCK_WORDS; w++) begin
            load_and_check(base + addr_t'(w), cycles);
            check_value("load stall cycles", cycles, 0);
        end
        drive_idle();
    endtask

    task automatic test_dirty_eviction();
        addr_t first;
        addr_t rival;
        word_t rdata;
        int cycles;
        first = 16'h0344;
        rival = first + addr_t'(1 << TAG_SHIFT);  // same index, next tag
        run_access(STORE, first, 16'h5a3c, rdata, cycles);
        load_and_check(rival, cycles);
        check_value("conflicting load stalled", cycles != 0, 1'b1);
        load_and_check(first, cycles);
        check_value("reload after eviction stalled", cycles != 0, 1'b1);
        drive_idle();
    endtask

    // two indices with four tags each make most accesses evict something
    task automatic test_random_traffic();
        mem_op_t op;
        addr_t addr;
        word_t wdata;
        word_t rdata;
        int cycles;
        int i;
        for (i = 0; i < RANDOM_OPS; i++) begin
            op = take_bits(1) ? STORE : LOAD;
            addr = addr_t'(take_bits(2)) << TAG_SHIFT;
            addr = addr | ((addr_t'(8'h60) + addr_t'(take_bits(1))) << 2);
            addr = addr | addr_t'(take_bits(2));
            wdata = take_bits(16);
            if (op == STORE) begin
                run_access(STORE, addr, wdata, rdata, cycles);
            end else begin
                load_and_check(addr, cycles);
            end
        end
        drive_idle();
    endtask

    initial begin
        n_rst = 1'b0;
        valid = 1'b0;
        access = '0;
        lfsr_state = 16'd69;
        foreach (shadow[i]) begin
            shadow[i] = '0;  // main memory starts out all zero
        end
        repeat (10) @(posedge clk);
        #1;
        n_rst = 1'b1;

        test_reset_idle();
        test_cold_load();
        test_line_stores();
        test_dirty_eviction();
        test_random_traffic();

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- tests/clock_gen.sv
module clock_gen #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD / 2) clk = ~clk;
        end
    end

endmodule

//--- src/data_memory_subsystem.sv
module data_memory_subsystem
    import nand_cpu_pkg::*;
#(
    parameter int INDEX_BITS = 8,
    parameter int LATENCY = 3
) (
    input  logic        clk,
    input  logic        n_rst,
    input  logic        valid,
    input  cpu_access_t access,
    output cpu_result_t result
);

    mem_request_t mem_req;    // cache to memory
    mem_response_t mem_resp;  // memory back to cache

    d_cache #(
        .INDEX_BITS(INDEX_BITS)
    ) u_d_cache (
        .clk     (clk),
        .n_rst   (n_rst),
        .valid   (valid),
        .access  (access),
        .result  (result),
        .mem_req (mem_req),
        .mem_resp(mem_resp)
    );

    main_memory #(
        .LATENCY(LATENCY)
    ) u_main_memory (
        .clk     (clk),
        .n_rst   (n_rst),
        .mem_req (mem_req),
        .mem_resp(mem_resp)
    );

endmodule

//--- src/main_memory.sv
module main_memory
    import nand_cpu_pkg::*;
#(
    parameter int LATENCY = 3
) (
    input  logic          clk,
    input  logic          n_rst,
    input  mem_request_t  mem_req,
    output mem_response_t mem_resp
);

    localparam int DEPTH = 2 ** $bits(block_addr_t);
    localparam int WAIT_BITS = $clog2(LATENCY + 1);
    localparam int BEAT_CNT_BITS = $clog2(BEATS);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        TRANSFER
    } mem_state_t;

    if (LATENCY < 1) begin : g_bad_latency
        $error("main_memory needs a LATENCY of at least 1");
    end

    mem_state_t state;
    logic [WAIT_BITS-1:0] wait_cnt;
    logic [BEAT_CNT_BITS-1:0] beat;
    logic last_beat;

    // captured with the request and held for the whole transfer
    block_addr_t addr;
    logic is_write;

    block_t blocks [DEPTH] = '{default: '0};

    assign last_beat = beat == BEAT_CNT_BITS'(BEATS - 1);

    // wait_cnt holds how many cycles have passed since the request was seen
    assign mem_resp.ack = (state == WAIT) && (wait_cnt == WAIT_BITS'(LATENCY));

    always_comb begin
        mem_resp.r_data = '0;
        if (state == TRANSFER && !is_write) begin
            mem_resp.r_data = blocks[addr][beat*BEAT_BITS +: BEAT_BITS];
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= IDLE;
            wait_cnt <= '0;
            beat <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (mem_req.req != REQ_NONE) begin
                        state <= WAIT;
                        wait_cnt <= WAIT_BITS'(1);
                    end
                end
                WAIT: begin
                    if (mem_resp.ack) begin
                        state <= TRANSFER;
                        beat <= '0;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                TRANSFER: begin
                    beat <= beat + 1'b1;
                    if (last_beat) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && mem_req.req != REQ_NONE) begin
            addr <= mem_req.address;
            is_write <= mem_req.req == REQ_WRITE;
        end
        if (state == TRANSFER && is_write) begin
            blocks[addr][beat*BEAT_BITS +: BEAT_BITS] <= mem_req.w_data;  // lowest beat first
        end
    end

    // the cache must have dropped its request once the beats are running
    a_quiet_during_transfer: assert property (
        @(posedge clk) disable iff (!n_rst)
        (state == TRANSFER) |-> (mem_req.req == REQ_NONE)
    );

endmodule

//--- src/d_cache.sv
module d_cache
    import nand_cpu_pkg::*;
#(
    parameter int INDEX_BITS = 8
) (
    input  logic          clk,
    input  logic          n_rst,
    input  logic          valid,
    input  cpu_access_t   access,
    output cpu_result_t   result,
    output mem_request_t  mem_req,
    input  mem_response_t mem_resp
);

    localparam int ADDR_BITS = $bits(addr_t);
    localparam int OFFSET_BITS = $clog2(BLOCK_WORDS);
    localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
    localparam int LINES = 2 ** INDEX_BITS;
    localparam int COUNTER_BITS = $clog2(BEATS);

    typedef enum logic [2:0] {
        READY,
        REQUEST_WRITE,
        WRITING,
        REQUEST_READ,
        READING
    } cache_state_t;

    cache_state_t state;
    cache_state_t next_state;

    logic [OFFSET_BITS-1:0] offset;
    logic [INDEX_BITS-1:0] index;
    logic [TAG_BITS-1:0] tag;

    logic [COUNTER_BITS-1:0] counter;
    logic last_beat;

    // line state indexed by the address index bits
    logic [LINES-1:0] line_valid;
    logic [LINES-1:0] line_dirty;
    logic [TAG_BITS-1:0] line_tag [LINES];
    block_t line_data [LINES];

    logic lookup;
    logic tag_match;
    logic store_hit;

    block_addr_t victim_addr;
    block_addr_t fill_addr;

    assign offset = access.address[OFFSET_BITS-1:0];
    assign index = access.address[INDEX_BITS+OFFSET_BITS-1:OFFSET_BITS];
    assign tag = access.address[ADDR_BITS-1:INDEX_BITS+OFFSET_BITS];

    assign lookup = valid & access.mem_access;
    assign tag_match = line_valid[index] & (line_tag[index] == tag);
    assign store_hit = result.hit & (access.mem_op == STORE);
    assign last_beat = counter == COUNTER_BITS'(BEATS - 1);

    // the victim goes back to where it came from, not to the new address
    assign victim_addr = {line_tag[index], index};
    assign fill_addr = {tag, index};

    always_comb begin
        next_state = state;

        result.hit = 1'b0;
        result.miss = 1'b1;  // any state but READY is part of a miss
        result.data = line_data[index][offset*WORD_BITS +: WORD_BITS];

        mem_req.req = REQ_NONE;
        mem_req.address = fill_addr;
        mem_req.w_data = line_data[index][counter*BEAT_BITS +: BEAT_BITS];

        case (state)
            READY: begin
                result.hit = lookup & tag_match;
                result.miss = lookup & ~tag_match;
                if (result.miss) begin
                    if (line_dirty[index]) begin
                        next_state = REQUEST_WRITE;
                    end else begin
                        next_state = REQUEST_READ;
                    end
                end
            end
            REQUEST_WRITE: begin
                mem_req.req = REQ_WRITE;
                mem_req.address = victim_addr;
                if (mem_resp.ack) begin
                    next_state = WRITING;
                end
            end
            WRITING: begin
                mem_req.address = victim_addr;
                if (last_beat) begin
                    next_state = REQUEST_READ;
                end
            end
            REQUEST_READ: begin
                mem_req.req = REQ_READ;
                if (mem_resp.ack) begin
                    next_state = READING;
                end
            end
            READING: begin
                if (last_beat) begin
                    next_state = READY;
                end
            end
            default: begin
                next_state = READY;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= READY;
            counter <= '0;
            line_valid <= '0;
            line_dirty <= '0;
        end else begin
            state <= next_state;
            case (state)
                READY: begin
                    if (store_hit) begin
                        line_dirty[index] <= 1'b1;
                    end
                end
                REQUEST_WRITE, REQUEST_READ: begin
                    counter <= '0;  // first beat follows the ack cycle
                end
                WRITING: begin
                    counter <= counter + 1'b1;
                    if (last_beat) begin
                        line_dirty[index] <= 1'b0;
                    end
                end
                READING: begin
                    counter <= counter + 1'b1;
                    if (last_beat) begin
                        line_valid[index] <= 1'b1;
                    end
                end
                default: begin
                    counter <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == READY && store_hit) begin
            line_data[index][offset*WORD_BITS +: WORD_BITS] <= access.data;
        end
        if (state == READING) begin
            line_data[index][counter*BEAT_BITS +: BEAT_BITS] <= mem_resp.r_data;
            if (last_beat) begin
                line_tag[index] <= tag;  // the line only turns valid with its last beat
            end
        end
    end

    // a refilled line must serve the held access as a hit and not as a miss
    a_refill_hits: assert property (
        @(posedge clk) disable iff (!n_rst)
        ($past(state == READING && last_beat) && lookup && $stable(access))
            |-> (result.hit && !result.miss)
    );

    // the memory must only answer a request the cache has raised
    a_no_stray_ack: assert property (
        @(posedge clk) disable iff (!n_rst)
        (state == READY && mem_req.req == REQ_NONE) |-> !mem_resp.ack
    );

endmodule

//--- src/nand_cpu_pkg.sv
package nand_cpu_pkg;

    localparam int WORD_BITS = 16;
    localparam int BLOCK_WORDS = 4;
    localparam int BEAT_BITS = 16;
    localparam int BEATS = 4;

    typedef logic [WORD_BITS-1:0] word_t;
    typedef logic [15:0] addr_t;
    typedef logic [WORD_BITS*BLOCK_WORDS-1:0] block_t;

    // word address with the offset bits dropped
    typedef logic [$bits(addr_t)-$clog2(BLOCK_WORDS)-1:0] block_addr_t;

    typedef enum logic {
        LOAD,
        STORE
    } mem_op_t;

    typedef enum logic [1:0] {
        REQ_NONE,
        REQ_READ,
        REQ_WRITE
    } cache_req_t;

    typedef struct packed {
        logic    mem_access;
        mem_op_t mem_op;
        addr_t   address;
        word_t   data;
    } cpu_access_t;

    typedef struct packed {
        logic  hit;
        logic  miss;
        word_t data;
    } cpu_result_t;

    typedef struct packed {
        cache_req_t           req;
        block_addr_t          address;
        logic [BEAT_BITS-1:0] w_data;
    } mem_request_t;

    typedef struct packed {
        logic                 ack;
        logic [BEAT_BITS-1:0] r_data;
    } mem_response_t;

endpackage
